//--- tb.f
logic/ro_pkg.sv
logic/id_free_list.sv
logic/line_splitter.sv
logic/line_unpacker.sv
logic/read_only_stage.sv
sim/ro_checker.sv
sim/tb_read_only_stage.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_read_only_stage
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Result: FAILED
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_read_only_stage.sv
`timescale 1ns/1ps

module tb_read_only_stage import ro_pkg::*; ();

   localparam int N_REQS       = 40;    // tags stay unique below 256
   localparam int STALL_MARGIN = 8;

   logic        clk;
   logic        rstn;
   logic        req_valid;
   logic        req_ready;
   ro_req_t     req;
   logic        arvalid;
   logic        arready;
   logic [31:0] araddr;
   mem_id_t     arid;
   logic        rvalid;
   logic        rready;
   mem_id_t     rid;
   line_t       rdata;
   logic        out_valid;
   logic        out_ready;
   ro_word_t    out;
   logic        idle;

   logic        finished;
   int          n_tests;
   int          n_failed;
   int          n_errors;

   logic [31:0] lfsr;
   logic [31:0] req_addr  [N_REQS];
   word_cnt_t   req_words [N_REQS];
   tag_t        req_tag   [N_REQS];
   int          req_gap   [N_REQS];   // idle cycles before each request
   int          next_req;
   int          gap_left;
   int          resp_wait;
   logic [31:0] pend_addr [$];        // read-address transfers not answered yet
   mem_id_t     pend_id   [$];
   int          total_words;
   int          limit;
   int          cycles;

   read_only_stage #(.LOG_THREADS(LOG_MAX_THREADS), .LOG_IDS(LOG_MAX_IDS)) UUT (
      .clk(clk), .rstn(rstn),
      .req_valid(req_valid), .req_ready(req_ready), .req(req),
      .arvalid(arvalid), .arready(arready), .araddr(araddr), .arid(arid),
      .rvalid(rvalid), .rready(rready), .rid(rid), .rdata(rdata),
      .out_valid(out_valid), .out_ready(out_ready), .out(out),
      .idle(idle)
   );

   ro_checker #(.N_REQS(N_REQS)) CHECK (
      .clk(clk), .rstn(rstn),
      .req_valid(req_valid), .req_ready(req_ready), .req(req),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid),
      .out_valid(out_valid), .out_ready(out_ready), .out(out),
      .idle(idle),
      .finished(finished), .n_tests(n_tests), .n_failed(n_failed), .n_errors(n_errors)
   );

   always #50 clk = ~clk;

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic word_t mem_word(input logic [31:0] a);
      return (a * 32'h9e37) ^ 32'h5a5a5a5a;
   endfunction

   function automatic line_t fetch_line(input logic [31:0] a);
      line_t l;
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
         l[i*32 +: 32] = mem_word({a[31:6], 6'b0} + 32'(4 * i));
      end
      return l;
   endfunction

   task automatic build_requests();
      logic [31:0] r;
      total_words = 0;
      for (int i = 0; i < N_REQS; i++) begin
         take_bits(28, r);
         req_addr[i] = {2'b00, r[27:0], 2'b00};   // low enough that a range never wraps
         take_bits(6, r);
         req_words[i] = {2'b00, r[5:0]} + 8'd1;
         take_bits(8, r);
         req_tag[i] = {r[7:0], 8'(i)};
         take_bits(2, r);
         req_gap[i] = int'(r[1:0]);
         total_words += int'(req_words[i]);
      end
   endtask

   // request source, port stalls and memory model share one lfsr
   always @(posedge clk) begin
      logic [31:0] r;
      int          pick;
      if (rstn) begin
         if (req_valid && req_ready) begin
            next_req = next_req + 1;
            if (next_req < N_REQS) begin
               gap_left = req_gap[next_req];
            end
         end
         if (!req_valid || req_ready) begin
            if (next_req < N_REQS && gap_left == 0) begin
               req_valid <= 1'b1;
               req       <= '{addr: req_addr[next_req], n_words: req_words[next_req],
                              tag: req_tag[next_req]};
            end else begin
               req_valid <= 1'b0;
               if (gap_left > 0) begin
                  gap_left = gap_left - 1;
               end
            end
         end

         take_bits(2, r);
         arready <= (r[1:0] != 2'b00);
         take_bits(2, r);
         out_ready <= (r[1:0] != 2'b00);

         if (arvalid && arready) begin
            pend_addr.push_back(araddr);
            pend_id.push_back(arid);
         end
         if (!rvalid || rready) begin
            if (pend_addr.size() > 0 && resp_wait == 0) begin
               take_bits(8, r);
               pick = int'(r[7:0]) % pend_addr.size();   // any order
               rvalid <= 1'b1;
               rid    <= pend_id[pick];
               rdata  <= fetch_line(pend_addr[pick]);
               pend_addr.delete(pick);
               pend_id.delete(pick);
               take_bits(2, r);
               resp_wait = int'(r[1:0]);
            end else begin
               rvalid <= 1'b0;
               if (resp_wait > 0) begin
                  resp_wait = resp_wait - 1;
               end
            end
         end
      end
   end

   initial begin
      clk       = 1'b0;
      rstn      = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      arready   = 1'b0;
      rvalid    = 1'b0;
      rid       = '0;
      rdata     = '0;
      out_ready = 1'b0;
      lfsr      = 32'h252c;
      next_req  = 0;
      resp_wait = 0;
      build_requests();
      gap_left  = req_gap[0];
      limit     = STALL_MARGIN * (total_words + 8 * N_REQS) + 100;
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      cycles = 0;
      while (!finished && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (!finished) begin
         $display("timeout: requests still in flight after %0d cycles", cycles);
      end
      $display("tests run %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
      if (finished && n_failed == 0 && n_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- sim/ro_checker.sv
`timescale 1ns/1ps

module ro_checker import ro_pkg::*; #(
   parameter int N_REQS = 40
) (
   input  logic        clk,
   input  logic        rstn,
   input  logic        req_valid,
   input  logic        req_ready,
   input  ro_req_t     req,
   input  logic        arvalid,
   input  logic        arready,
   input  logic [31:0] araddr,
   input  logic        rvalid,
   input  logic        out_valid,
   input  logic        out_ready,
   input  ro_word_t    out,
   input  logic        idle,
   output logic        finished,
   output int          n_tests,
   output int          n_failed,
   output int          n_errors
);

   logic [31:0] base_addr [tag_t];
   int          n_words   [tag_t];
   int          n_seen    [tag_t];
   int          n_lines   [tag_t];
   logic [63:0] seen_ids  [tag_t];   // one bit per word_id
   int          bad       [tag_t];
   tag_t        split_q   [$];       // requests still on the read-address port, oldest first
   int          done_reqs;
   int          drain;

   function automatic word_t mem_word(input logic [31:0] a);
      return (a * 32'h9e37) ^ 32'h5a5a5a5a;
   endfunction

   // lines touched by the byte range of a request
   function automatic int line_span(input logic [31:0] a, input int n);
      logic [31:0] last_byte;
      last_byte = a + 32'(4 * n - 4);
      return int'(last_byte[31:6] - a[31:6]) + 1;
   endfunction

   task automatic value_error(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      n_errors++;
   endtask

   task automatic close_request(input tag_t t);
      logic [63:0] want;
      int          span;
      want = (n_words[t] == 64) ? '1 : (64'd1 << n_words[t]) - 64'd1;
      span = line_span(base_addr[t], n_words[t]);
      if (seen_ids[t] !== want) begin
         $display("tag 0x%h did not return every word_id, seen mask 0x%h", t, seen_ids[t]);
         n_errors++;
         bad[t]++;
      end
      if (n_lines[t] != span) begin
         $display("tag 0x%h issued %0d line reads where its range covers %0d lines",
                  t, n_lines[t], span);
         n_errors++;
         bad[t]++;
      end
      n_tests++;
      if (bad[t] != 0) begin
         n_failed++;
      end
      $display("test %0d tag 0x%h addr 0x%h words %0d lines %0d: %s", n_tests, t,
               base_addr[t], n_words[t], n_lines[t], (bad[t] == 0) ? "ok" : "bad");
      base_addr.delete(t);
      n_words.delete(t);
      n_seen.delete(t);
      n_lines.delete(t);
      seen_ids.delete(t);
      bad.delete(t);
      done_reqs++;
   endtask

   always @(posedge clk) begin
      tag_t        t;
      logic [31:0] exp_addr;
      word_t       exp_data;
      int          err_before;
      if (!rstn) begin
         finished  = 1'b0;
         n_tests   = 0;
         n_failed  = 0;
         n_errors  = 0;
         done_reqs = 0;
         drain     = 0;
      end else begin
         if (arvalid && arready) begin
            if (split_q.size() == 0) begin
               $display("read-address transfer at 0x%h while no request is open", araddr);
               n_errors++;
            end else begin
               t        = split_q[0];
               exp_addr = (n_lines[t] == 0) ? base_addr[t] :
                          {base_addr[t][31:6] + 26'(n_lines[t]), 6'b0};
               if (araddr !== exp_addr) begin   // later beats must sit on a line start
                  value_error("araddr", 64'(araddr), 64'(exp_addr));
                  bad[t]++;
               end
               n_lines[t]++;
               if (n_lines[t] == line_span(base_addr[t], n_words[t])) begin
                  split_q.delete(0);
               end
            end
         end

         if (req_valid && req_ready) begin
            t            = req.tag;
            base_addr[t] = req.addr;
            n_words[t]   = int'(req.n_words);
            n_seen[t]    = 0;
            n_lines[t]   = 0;
            seen_ids[t]  = '0;
            bad[t]       = 0;
            split_q.push_back(t);
         end

         if (out_valid && out_ready) begin
            t = out.tag;
            if (!n_words.exists(t)) begin
               $display("output word with tag 0x%h belongs to no open request", t);
               n_errors++;
            end else begin
               if (int'(out.word_id) >= n_words[t]) begin
                  value_error("out.word_id", 64'(out.word_id), 64'(n_words[t] - 1));
                  bad[t]++;
               end else begin
                  if (seen_ids[t][out.word_id[5:0]]) begin
                     $display("tag 0x%h sent word_id %0d twice", t, out.word_id);
                     n_errors++;
                     bad[t]++;
                  end
                  seen_ids[t] = seen_ids[t] | (64'd1 << out.word_id[5:0]);
                  exp_data = mem_word(base_addr[t] + {22'b0, out.word_id, 2'b00});
                  if (out.data !== exp_data) begin
                     value_error("out.data", 64'(out.data), 64'(exp_data));
                     bad[t]++;
                  end
               end
               n_seen[t]++;
               if (out.last !== (n_seen[t] == n_words[t])) begin
                  value_error("out.last", 64'(out.last), 64'(n_seen[t] == n_words[t]));
                  bad[t]++;
               end
               if (n_seen[t] == n_words[t]) begin
                  close_request(t);
               end
            end
         end

         // let the last thread release settle, then look at the quiet state
         if (done_reqs == N_REQS && !finished) begin
            drain++;
            if (drain == 4) begin
               err_before = n_errors;
               if (idle !== 1'b1) value_error("idle", 64'(idle), 64'd1);
               if (out_valid !== 1'b0) value_error("out_valid", 64'(out_valid), 64'd0);
               if (arvalid !== 1'b0) value_error("arvalid", 64'(arvalid), 64'd0);
               if (rvalid !== 1'b0) value_error("rvalid", 64'(rvalid), 64'd0);
               n_tests++;
               if (n_errors != err_before) begin
                  n_failed++;
               end
               $display("test %0d end state idle %0b out_valid %0b arvalid %0b: %s", n_tests,
                        idle, out_valid, arvalid, (n_errors == err_before) ? "ok" : "bad");
               finished = 1'b1;
            end
         end
      end
   end

endmodule

//--- logic/read_only_stage.sv
`timescale 1ns/1ps

module read_only_stage import ro_pkg::*; #(
   parameter int LOG_THREADS = LOG_MAX_THREADS,
   parameter int LOG_IDS     = LOG_MAX_IDS
) (
   input  logic        clk,
   input  logic        rstn,

   input  logic        req_valid,
   output logic        req_ready,
   input  ro_req_t     req,

   output logic        arvalid,
   input  logic        arready,
   output logic [31:0] araddr,
   output mem_id_t     arid,

   input  logic        rvalid,
   output logic        rready,
   input  mem_id_t     rid,
   input  line_t       rdata,

   output logic        out_valid,
   input  logic        out_ready,
   output ro_word_t    out,

   output logic        idle   // every thread back in the pool
);

   logic                   thread_alloc;
   logic                   thread_empty;
   logic [LOG_THREADS-1:0] thread_next;
   logic                   thread_init_valid;
   thread_ctx_t            thread_init;
   logic                   thread_release_valid;
   thread_id_t             thread_release;

   logic                   mem_id_alloc;
   logic                   mem_id_empty;
   logic [LOG_IDS-1:0]     mem_next;
   logic                   mem_id_release;
   logic                   mshr_wr_valid;
   mshr_entry_t            mshr_wr;

   assign arid = mem_id_t'(mem_next);

   line_splitter SPLITTER (
      .clk(clk), .rstn(rstn),
      .req_valid(req_valid), .req_ready(req_ready), .req(req),
      .thread_id(thread_id_t'(thread_next)), .thread_empty(thread_empty),
      .thread_alloc(thread_alloc),
      .thread_init_valid(thread_init_valid), .thread_init(thread_init),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .mem_id_empty(mem_id_empty), .mem_id_alloc(mem_id_alloc),
      .mshr_wr_valid(mshr_wr_valid), .mshr_wr(mshr_wr)
   );

   line_unpacker #(.LOG_THREADS(LOG_THREADS), .LOG_IDS(LOG_IDS)) UNPACKER (
      .clk(clk), .rstn(rstn),
      .thread_init_valid(thread_init_valid), .thread_init(thread_init),
      .mshr_wr_valid(mshr_wr_valid), .mshr_wr(mshr_wr), .mshr_wr_id(arid),
      .rvalid(rvalid), .rready(rready), .rid(rid), .rdata(rdata),
      .mem_id_release(mem_id_release),
      .out_valid(out_valid), .out_ready(out_ready), .out(out),
      .thread_release_valid(thread_release_valid), .thread_release(thread_release)
   );

   id_free_list #(.LOG_DEPTH(LOG_THREADS)) THREAD_IDS (
      .clk(clk), .rstn(rstn),
      .alloc(thread_alloc),
      .release_valid(thread_release_valid),
      .release_id(thread_release[LOG_THREADS-1:0]),
      .next_id(thread_next), .empty(thread_empty), .full(idle)
   );

   id_free_list #(.LOG_DEPTH(LOG_IDS)) MEM_IDS (
      .clk(clk), .rstn(rstn),
      .alloc(mem_id_alloc),
      .release_valid(mem_id_release),
      .release_id(rid[LOG_IDS-1:0]),
      .next_id(mem_next), .empty(mem_id_empty), .full()
   );

endmodule

//--- logic/line_unpacker.sv
`timescale 1ns/1ps

module line_unpacker import ro_pkg::*; #(
   parameter int LOG_THREADS = 3,
   parameter int LOG_IDS     = 5
) (
   input  logic        clk,
   input  logic        rstn,

   input  logic        thread_init_valid,
   input  thread_ctx_t thread_init,

   input  logic        mshr_wr_valid,
   input  mshr_entry_t mshr_wr,
   input  mem_id_t     mshr_wr_id,

   input  logic        rvalid,
   output logic        rready,
   input  mem_id_t     rid,
   input  line_t       rdata,
   output logic        mem_id_release,

   output logic        out_valid,
   input  logic        out_ready,
   output ro_word_t    out,

   output logic        thread_release_valid,
   output thread_id_t  thread_release
);

   localparam int N_THREADS = 2**LOG_THREADS;
   localparam int N_IDS     = 2**LOG_IDS;

   mshr_entry_t mshr_mem [N_IDS];
   tag_t        tag_mem  [N_THREADS];
   word_cnt_t   rem_words [N_THREADS];   // words still owed to each thread

   logic                      hold_valid;
   line_t                     hold_data;
   thread_id_t                hold_thread;
   logic [WORDS_PER_LINE-1:0] hold_mask;
   word_cnt_t                 out_word_id;

   logic [LOG_IDS-1:0]        rid_idx;
   mshr_entry_t               resp_entry;
   word_cnt_t                 resp_rem;
   word_idx_t                 word_sel;
   logic [WORDS_PER_LINE-1:0] next_mask;
   logic                      r_fire;
   logic                      out_fire;
   word_cnt_t                 hold_rem;

   assign rid_idx    = rid[LOG_IDS-1:0];
   assign resp_entry = mshr_mem[rid_idx];
   assign resp_rem   = rem_words[resp_entry.thread[LOG_THREADS-1:0]];
   assign hold_rem   = rem_words[hold_thread[LOG_THREADS-1:0]];

   always_ff @(posedge clk) begin
      if (mshr_wr_valid) begin
         mshr_mem[mshr_wr_id[LOG_IDS-1:0]] <= mshr_wr;
      end
      if (thread_init_valid) begin
         tag_mem[thread_init.thread[LOG_THREADS-1:0]] <= thread_init.tag;
      end
   end

   // lowest pending word of the held line
   always_comb begin
      word_sel = '0;
      for (int i = WORDS_PER_LINE - 1; i >= 0; i--) begin
         if (hold_mask[i]) begin
            word_sel = word_idx_t'(i);
         end
      end
      next_mask           = hold_mask;
      next_mask[word_sel] = 1'b0;
   end

   assign out_valid = hold_valid;
   assign out_fire  = out_valid & out_ready;
   assign rready    = !hold_valid | (out_fire & (next_mask == '0));
   assign r_fire    = rvalid & rready;

   assign out.tag     = tag_mem[hold_thread[LOG_THREADS-1:0]];
   assign out.word_id = out_word_id;
   assign out.data    = hold_data[word_sel*32 +: 32];
   assign out.last    = (hold_rem == 8'd1);

   assign mem_id_release       = r_fire;   // entry is copied out on this edge
   assign thread_release_valid = out_fire & out.last;
   assign thread_release       = hold_thread;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         hold_valid <= 1'b0;
      end else if (r_fire) begin
         hold_valid <= 1'b1;
      end else if (out_fire & (next_mask == '0)) begin
         hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         hold_data   <= rdata;
         hold_thread <= resp_entry.thread;
         hold_mask   <= resp_entry.valid_words;
         out_word_id <= resp_entry.start_word;
      end else if (out_fire) begin
         hold_mask   <= next_mask;
         out_word_id <= out_word_id + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int t = 0; t < N_THREADS; t++) begin
            rem_words[t] <= '0;
         end
      end else begin
         for (int t = 0; t < N_THREADS; t++) begin
            if (thread_init_valid && (thread_init.thread[LOG_THREADS-1:0] == t)) begin
               rem_words[t] <= thread_init.n_words;
            end else if (out_fire && (hold_thread[LOG_THREADS-1:0] == t)) begin
               rem_words[t] <= rem_words[t] - 1'b1;
            end
         end
      end
   end

   // every line must belong to a thread that still owes words
   a_resp_live_thread: assert property (@(posedge clk) disable iff (!rstn)
      r_fire |-> resp_rem != '0);

endmodule

//--- logic/line_splitter.sv
`timescale 1ns/1ps

module line_splitter import ro_pkg::*; (
   input  logic        clk,
   input  logic        rstn,

   input  logic        req_valid,
   output logic        req_ready,
   input  ro_req_t     req,

   input  thread_id_t  thread_id,
   input  logic        thread_empty,
   output logic        thread_alloc,
   output logic        thread_init_valid,
   output thread_ctx_t thread_init,

   output logic        arvalid,
   input  logic        arready,
   output logic [31:0] araddr,

   input  logic        mem_id_empty,
   output logic        mem_id_alloc,
   output logic        mshr_wr_valid,
   output mshr_entry_t mshr_wr
);

   logic        busy;           // a request is being split
   logic [31:0] cur_addr;
   word_cnt_t   rem_words;
   word_cnt_t   start_word;
   thread_id_t  cur_thread;

   word_idx_t   line_off;
   logic [4:0]  words_in_line;
   logic [4:0]  beat_words;
   logic [4:0]  end_word;
   logic        last_beat;
   logic        ar_fire;
   logic        req_fire;
   logic [WORDS_PER_LINE-1:0] mask;

   always_comb begin
      line_off      = cur_addr[5:2];
      words_in_line = 5'd16 - {1'b0, line_off};
      last_beat     = (rem_words <= {3'b0, words_in_line});
      beat_words    = last_beat ? rem_words[4:0] : words_in_line;
      end_word      = {1'b0, line_off} + beat_words;   // never past 16
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
         mask[i] = (5'(i) >= {1'b0, line_off}) && (5'(i) < end_word);
      end
   end

   assign arvalid   = busy & !mem_id_empty;
   assign araddr    = cur_addr;
   assign ar_fire   = arvalid & arready;
   assign req_ready = !thread_empty & (!busy | (ar_fire & last_beat));
   assign req_fire  = req_valid & req_ready;

   assign thread_alloc      = req_fire;
   assign thread_init_valid = req_fire;
   assign thread_init       = '{thread: thread_id, tag: req.tag, n_words: req.n_words};

   assign mem_id_alloc  = ar_fire;
   assign mshr_wr_valid = ar_fire;
   assign mshr_wr       = '{thread: cur_thread, valid_words: mask, start_word: start_word};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (req_fire) begin
         busy <= 1'b1;
      end else if (ar_fire & last_beat) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         cur_addr   <= req.addr;
         rem_words  <= req.n_words;
         start_word <= '0;
         cur_thread <= thread_id;
      end else if (ar_fire) begin
         cur_addr   <= {cur_addr[31:6] + 1'b1, 6'b0};   // next line
         rem_words  <= rem_words - {3'b0, beat_words};
         start_word <= start_word + {3'b0, beat_words};
      end
   end

   // a waiting beat keeps valid and address until it is taken
   a_araddr_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

//--- logic/id_free_list.sv
`timescale 1ns/1ps

module id_free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 alloc,
   input  logic                 release_valid,
   input  logic [LOG_DEPTH-1:0] release_id,
   output logic [LOG_DEPTH-1:0] next_id,
   output logic                 empty,
   output logic                 full
);

   localparam int DEPTH = 2**LOG_DEPTH;

   logic [LOG_DEPTH-1:0] ids [DEPTH];
   logic [LOG_DEPTH-1:0] head;
   logic [LOG_DEPTH-1:0] tail;
   logic [LOG_DEPTH:0]   count;

   // ring starts full with every id in order
   always_ff @(posedge clk) begin
      if (!rstn) begin
         head  <= '0;
         tail  <= '0;
         count <= DEPTH[LOG_DEPTH:0];
         for (int i = 0; i < DEPTH; i++) begin
            ids[i] <= LOG_DEPTH'(i);
         end
      end else begin
         if (alloc) begin
            head <= head + 1'b1;
         end
         if (release_valid) begin
            ids[tail] <= release_id;
            tail      <= tail + 1'b1;
         end
         case ({alloc, release_valid})
            2'b10:   count <= count - 1'b1;
            2'b01:   count <= count + 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign next_id = ids[head];
   assign empty   = (count == '0);
   assign full    = (count == DEPTH[LOG_DEPTH:0]);

   // callers must respect empty and full
   a_no_over_under: assert property (@(posedge clk) disable iff (!rstn)
      !(alloc && empty) && !(release_valid && full));

endmodule

//--- logic/ro_pkg.sv
package ro_pkg;

   localparam int WORDS_PER_LINE  = 16;
   localparam int LINE_BITS       = 512;
   localparam int LOG_MAX_THREADS = 3;
   localparam int LOG_MAX_IDS     = 5;
   localparam int MAX_REQ_WORDS   = 64;

   typedef logic [31:0]                word_t;
   typedef logic [LINE_BITS-1:0]       line_t;
   typedef logic [3:0]                 word_idx_t;
   typedef logic [7:0]                 word_cnt_t;   // count, or position in a request
   typedef logic [15:0]                tag_t;
   typedef logic [LOG_MAX_THREADS-1:0] thread_id_t;
   typedef logic [LOG_MAX_IDS-1:0]     mem_id_t;

   typedef struct packed {
      logic [31:0] addr;   // word aligned byte address
      word_cnt_t   n_words;
      tag_t        tag;
   } ro_req_t;

   typedef struct packed {
      tag_t      tag;
      word_cnt_t word_id;
      word_t     data;
      logic      last;
   } ro_word_t;

   // one entry per outstanding line read
   typedef struct packed {
      thread_id_t                thread;
      logic [WORDS_PER_LINE-1:0] valid_words;
      word_cnt_t                 start_word;   // request position of the first valid word
   } mshr_entry_t;

   typedef struct packed {
      thread_id_t thread;
      tag_t       tag;
      word_cnt_t  n_words;
   } thread_ctx_t;

endpackage
